//--- all.f
+incdir+testbench
design/lsu_pkg.sv
design/lsu_ctrl.sv
design/wait_timer.sv
design/store_align.sv
design/load_align.sv
design/data_ram.sv
design/lsu_top.sv
testbench/tb_lsu.sv

//--- design/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_AW = 8
) (
  input  logic                clk,
  input  logic [RAM_AW-1:0]   index,
  input  lsu_pkg::ram_wr_t    wr,
  output lsu_pkg::dword_t     rdword
);
  import lsu_pkg::*;

  localparam int DEPTH = 2 ** RAM_AW;

  dword_t mem [DEPTH]; // contents undefined until written.

  // byte masked write, only enabled lanes change.
  always_ff @(posedge clk) begin
    if (wr.en) begin
      for (int i = 0; i < 8; i++) begin
        if (wr.mask[i]) mem[index][i*8 +: 8] <= wr.data[i*8 +: 8];
      end
    end
  end

  // registered read every cycle, old data on a same-cycle write.
  always_ff @(posedge clk) begin
    rdword <= mem[index];
  end

endmodule

//--- design/load_align.sv
`timescale 1ns/1ps

module load_align (
  input  logic              clk,
  input  logic              rst,
  input  logic              capture,
  input  lsu_pkg::lsu_req_t held,
  input  lsu_pkg::dword_t   rdword,
  output lsu_pkg::dword_t   rdata
);
  import lsu_pkg::*;

  logic [2:0]  off;
  logic [7:0]  b_lane;
  logic [15:0] h_lane;
  logic [31:0] w_lane;
  dword_t      ext;

  assign off = held.addr[2:0];

  // lane pick, halfword and word follow the aligned slot.
  always_comb begin
    b_lane = rdword[{off, 3'b000} +: 8];
    h_lane = rdword[{off[2:1], 4'b0000} +: 16];
    w_lane = off[2] ? rdword[63:32] : rdword[31:0];
  end

  always_comb begin
    case (held.mem_op)
      LB:      ext = {{56{b_lane[7]}}, b_lane};
      LBU:     ext = {56'h0, b_lane};
      LH:      ext = {{48{h_lane[15]}}, h_lane};
      LHU:     ext = {48'h0, h_lane};
      LW:      ext = {{32{w_lane[31]}}, w_lane};
      LWU:     ext = {32'h0, w_lane};
      default: ext = rdword; // LD passes through.
    endcase
  end

  // result holds until the next load completes.
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else if (capture) begin
      rdata <= ext;
    end
  end

endmodule

//--- design/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl #(
  parameter int WAIT_CYCLES = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  lsu_pkg::lsu_req_t req_data,
  input  logic              expired,
  output lsu_pkg::lsu_req_t held,
  output logic              timer_load,
  output logic              mem_write,
  output logic              load_capture,
  output logic              busy,
  output logic              done,
  output logic              error
);
  import lsu_pkg::*;

  lsu_state_e state;
  logic       misalign;      // alignment check on the incoming request.
  logic       err_q;         // the access in flight was rejected.
  logic       accept;        // request taken this cycle.
  logic       access_end;    // last cycle of ACCESS.

  // the wait state count has to be at least one.
  if (WAIT_CYCLES < 1) begin : g_bad_wait
    $error("lsu_ctrl: WAIT_CYCLES must be 1 or more");
  end

  // natural alignment by size, bytes never fault.
  always_comb begin
    case (req_data.mem_op[1:0])
      2'b01:   misalign = req_data.addr[0];
      2'b10:   misalign = |req_data.addr[1:0];
      2'b11:   misalign = |req_data.addr[2:0];
      default: misalign = 1'b0;
    endcase
  end

  assign accept     = (state == IDLE) && req;      // req ignored unless idle.
  assign access_end = (state == ACCESS) && expired;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      err_q      <= 1'b0;
      timer_load <= 1'b0;
    end else begin
      timer_load <= accept && !misalign; // starts the timer in the first ACCESS cycle.
      case (state)
        IDLE: begin
          if (req) begin
            state <= misalign ? FINISH : ACCESS; // bad address skips memory.
            err_q <= misalign;
          end
        end
        ACCESS:  if (expired) state <= FINISH;
        FINISH:  state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // held copy of the request, steady until the next accept.
  always_ff @(posedge clk) begin
    if (accept) held <= req_data;
  end

  assign mem_write    = access_end && held.write;  // store lands on the exit edge.
  assign load_capture = access_end && !held.write; // load result registered on exit.
  assign busy         = (state != IDLE);
  assign done         = (state == FINISH) && !err_q;
  assign error        = (state == FINISH) && err_q;

endmodule

//--- design/lsu_pkg.sv
package lsu_pkg;

  // byte address as seen by the requester.
  typedef logic [31:0] addr_t;

  // one doubleword of data, the width of a ram row.
  typedef logic [63:0] dword_t;

  // one enable bit per byte lane of a doubleword.
  typedef logic [7:0] bmask_t;

  // riscv access code.
  // bit 2 marks an unsigned load, bits 1:0 give the size.
  typedef enum logic [2:0] {
    LB  = 3'b000, // byte, sign extended.
    LH  = 3'b001, // halfword, sign extended.
    LW  = 3'b010, // word, sign extended.
    LD  = 3'b011, // doubleword.
    LBU = 3'b100, // byte, zero extended.
    LHU = 3'b101, // halfword, zero extended.
    LWU = 3'b110  // word, zero extended.
  } mem_op_e;

  // controller states, one access in flight at most.
  typedef enum logic [1:0] {
    IDLE   = 2'd0, // waiting for req.
    ACCESS = 2'd1, // memory wait states running.
    FINISH = 2'd2  // done or error pulse.
  } lsu_state_e;

  // one memory request as driven by the requester.
  typedef struct packed {
    logic    write;  // 1 for a store.
    mem_op_e mem_op; // size and signedness.
    addr_t   addr;   // byte address.
    dword_t  wdata;  // store data, right aligned.
  } lsu_req_t;

  // ram write port bundle.
  typedef struct packed {
    logic   en;   // write enable.
    dword_t data; // lane replicated store data.
    bmask_t mask; // byte lanes to update.
  } ram_wr_t;

endpackage

//--- design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int WAIT_CYCLES = 2,
  parameter int RAM_AW      = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  lsu_pkg::lsu_req_t req_data,
  output logic              busy,
  output logic              done,
  output logic              error,
  output lsu_pkg::dword_t   rdata
);
  import lsu_pkg::*;

  lsu_req_t          held;         // request under way.
  logic              timer_load;
  logic              expired;
  logic              mem_write;
  logic              load_capture;
  ram_wr_t           wr_lane;      // aligner output, always enabled.
  ram_wr_t           wr_ram;       // qualified write to the ram.
  dword_t            rdword;
  logic [RAM_AW-1:0] ram_index;

  lsu_ctrl #(.WAIT_CYCLES(WAIT_CYCLES)) u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .req_data     (req_data),
    .expired      (expired),
    .held         (held),
    .timer_load   (timer_load),
    .mem_write    (mem_write),
    .load_capture (load_capture),
    .busy         (busy),
    .done         (done),
    .error        (error)
  );

  wait_timer #(.WAIT_CYCLES(WAIT_CYCLES)) u_timer (
    .clk     (clk),
    .rst     (rst),
    .load    (timer_load),
    .expired (expired)
  );

  store_align u_store (.held(held), .wr(wr_lane));

  // doubleword index, upper address bits wrap off the top.
  assign ram_index = held.addr[RAM_AW+2:3];

  assign wr_ram.en   = wr_lane.en && mem_write; // one strobe from the controller.
  assign wr_ram.data = wr_lane.data;
  assign wr_ram.mask = wr_lane.mask;

  data_ram #(.RAM_AW(RAM_AW)) u_ram (
    .clk    (clk),
    .index  (ram_index),
    .wr     (wr_ram),
    .rdword (rdword)
  );

  load_align u_load (
    .clk     (clk),
    .rst     (rst),
    .capture (load_capture),
    .held    (held),
    .rdword  (rdword),
    .rdata   (rdata)
  );

endmodule

//--- design/store_align.sv
`timescale 1ns/1ps

module store_align (
  input  lsu_pkg::lsu_req_t held,
  output lsu_pkg::ram_wr_t  wr
);
  import lsu_pkg::*;

  logic [2:0] off;    // byte offset in the doubleword.
  dword_t     data;
  bmask_t     mask;

  assign off = held.addr[2:0];

  always_comb begin
    case (held.mem_op[1:0]) // stores only look at the size bits.
      2'b00: begin
        data = {8{held.wdata[7:0]}};   // byte copied to every lane.
        mask = bmask_t'(1) << off;
      end
      2'b01: begin
        data = {4{held.wdata[15:0]}};  // halfword in all four slots.
        mask = bmask_t'(2'b11) << {off[2:1], 1'b0};
      end
      2'b10: begin
        data = {2{held.wdata[31:0]}};  // word in both halves.
        mask = off[2] ? 8'hf0 : 8'h0f;
      end
      default: begin
        data = held.wdata;             // doubleword as is.
        mask = 8'hff;
      end
    endcase
  end

  // en stays high here, the controller strobe qualifies it at the top.
  assign wr.en   = 1'b1;
  assign wr.data = data;
  assign wr.mask = mask;

endmodule

//--- design/wait_timer.sv
`timescale 1ns/1ps

module wait_timer #(
  parameter int WAIT_CYCLES = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic load,
  output logic expired
);
  localparam int CW = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;
  localparam logic [CW-1:0] LOAD_VAL = CW'(WAIT_CYCLES - 1); // zero for one wait state.

  logic [CW-1:0] count;
  logic          running; // low while idle.

  always_ff @(posedge clk) begin
    if (rst) begin
      count   <= '0;
      running <= 1'b0;
    end else if (load) begin
      count   <= LOAD_VAL;
      running <= 1'b1;
    end else if (running) begin
      if (count == '0) running <= 1'b0; // expiry lasts one cycle.
      else count <= count - 1'b1;
    end
  end

  // a load in the same cycle hides a stale zero.
  assign expired = running && (count == '0) && !load;

endmodule

//--- run.sh
#!/bin/sh
# build the load/store unit testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_lsu -Mdir obj_dir -f all.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

output=$(./obj_dir/Vtb_lsu 2>&1)
run_status=$?
echo "$output"

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
  echo "simulation passed"
  exit 0
fi

echo "simulation did not report a pass"
exit 1

//--- testbench/lsu_vectors.svh
task automatic fill_table();
  // columns: write, mem_op, byte address, wdata, expect error, expect ignore.
  // stores reuse the load codes, only the size bits count.

  // seed three doublewords, 0x48 holds lanes with mixed sign bits.
  add_row(1'b1, LD,  32'h0000_0040, random_dword(),        1'b0, 1'b0);
  add_row(1'b1, LD,  32'h0000_0048, 64'h7fa5_c3e1_8001_7f80, 1'b0, 1'b0);
  add_row(1'b1, LD,  32'h0000_0050, random_dword(),        1'b0, 1'b0);

  // every byte lane of 0x40, the whole doubleword read back each time.
  add_row(1'b1, LB,  32'h0000_0040, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LB,  32'h0000_0041, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LB,  32'h0000_0042, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LB,  32'h0000_0043, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LB,  32'h0000_0044, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LB,  32'h0000_0045, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LB,  32'h0000_0046, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LB,  32'h0000_0047, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  // halfword, word and doubleword lanes of the same row.
  add_row(1'b1, LH,  32'h0000_0040, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LH,  32'h0000_0042, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LH,  32'h0000_0044, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LH,  32'h0000_0046, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LW,  32'h0000_0040, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LW,  32'h0000_0044, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LD,  32'h0000_0040, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);

  // narrow loads from 0x48, lane top bit set and clear for each kind.
  add_row(1'b0, LB,  32'h0000_0048, 64'h0, 1'b0, 1'b0); // 0x80.
  add_row(1'b0, LB,  32'h0000_0049, 64'h0, 1'b0, 1'b0); // 0x7f.
  add_row(1'b0, LBU, 32'h0000_004c, 64'h0, 1'b0, 1'b0); // 0xe1.
  add_row(1'b0, LBU, 32'h0000_004f, 64'h0, 1'b0, 1'b0);
  add_row(1'b0, LH,  32'h0000_004a, 64'h0, 1'b0, 1'b0); // 0x8001.
  add_row(1'b0, LH,  32'h0000_0048, 64'h0, 1'b0, 1'b0);
  add_row(1'b0, LHU, 32'h0000_004c, 64'h0, 1'b0, 1'b0);
  add_row(1'b0, LHU, 32'h0000_004e, 64'h0, 1'b0, 1'b0);
  add_row(1'b0, LW,  32'h0000_0048, 64'h0, 1'b0, 1'b0);
  add_row(1'b0, LW,  32'h0000_004c, 64'h0, 1'b0, 1'b0);
  add_row(1'b0, LWU, 32'h0000_0048, 64'h0, 1'b0, 1'b0);
  add_row(1'b0, LWU, 32'h0000_004c, 64'h0, 1'b0, 1'b0);

  // misaligned reads and writes, memory at 0x50 must stay put.
  add_row(1'b1, LH,  32'h0000_0051, random_dword(), 1'b1, 1'b0);
  add_row(1'b0, LH,  32'h0000_0053, 64'h0,          1'b1, 1'b0);
  add_row(1'b1, LW,  32'h0000_0052, random_dword(), 1'b1, 1'b0);
  add_row(1'b0, LW,  32'h0000_0051, 64'h0,          1'b1, 1'b0);
  add_row(1'b1, LD,  32'h0000_0054, random_dword(), 1'b1, 1'b0);
  add_row(1'b0, LD,  32'h0000_0057, 64'h0,          1'b1, 1'b0);
  add_row(1'b0, LHU, 32'h0000_0055, 64'h0,          1'b1, 1'b0);
  add_row(1'b0, LWU, 32'h0000_0056, 64'h0,          1'b1, 1'b0);
  add_row(1'b0, LD,  32'h0000_0050, 64'h0,          1'b0, 1'b0);

  // second req while busy, only the first one may land.
  add_row(1'b1, LD,  32'h0000_0050, random_dword(), 1'b0, 1'b0);
  add_row(1'b1, LD,  32'h0000_0050, random_dword(), 1'b0, 1'b1);
  add_row(1'b0, LD,  32'h0000_0050, 64'h0,          1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0048, 64'h0,          1'b0, 1'b0);
  add_row(1'b1, LB,  32'h0000_0048, 64'h55,         1'b0, 1'b1);
  add_row(1'b0, LB,  32'h0000_0048, 64'h0,          1'b0, 1'b0);

  // addresses past the ram wrap back onto row 0x40.
  add_row(1'b1, LW,  32'h0001_0844, random_dword(), 1'b0, 1'b0);
  add_row(1'b0, LD,  32'h0000_0040, 64'h0,          1'b0, 1'b0);
  add_row(1'b0, LWU, 32'h0001_0844, 64'h0,          1'b0, 1'b0);
endtask

//--- testbench/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;
  import lsu_pkg::*;

  localparam int WAIT_CYCLES = 2;
  localparam int RAM_AW      = 8;
  localparam int RAM_BYTES   = 8 * (2 ** RAM_AW); // byte size of the ram.

  typedef struct packed {
    lsu_req_t req;     // request as driven.
    logic     exp_err; // misaligned so an error pulse is expected.
    logic     ignore;  // pulsed while the previous row is busy.
  } row_t;

  logic     clk = 1'b0;
  logic     rst;
  logic     req;
  lsu_req_t req_data;
  logic     busy;
  logic     done;
  logic     error;
  dword_t   rdata;

  row_t       rows [$];
  logic [7:0] ref_mem [RAM_BYTES]; // byte image of the ram.
  dword_t     expect_rdata = '0;   // last completed load.
  integer     seed;
  bit         table_ready = 1'b0;

  lsu_top #(.WAIT_CYCLES(WAIT_CYCLES), .RAM_AW(RAM_AW)) u_dut (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_data (req_data),
    .busy     (busy),
    .done     (done),
    .error    (error),
    .rdata    (rdata)
  );

  always #10 clk = ~clk; // 20 ns period.

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input dword_t actual, input dword_t expected);
    if (actual !== expected) begin
      $display("Fail time=%0t %s: got %h expected %h", $time, name, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  task automatic check_idle();
    check_value("busy", 64'(busy), 64'd0);
    check_value("done", 64'(done), 64'd0);
    check_value("error", 64'(error), 64'd0);
  endtask

  function automatic dword_t random_dword();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic add_row(input logic write, input mem_op_e op, input addr_t addr,
                         input dword_t wdata, input logic exp_err, input logic ignore);
    row_t r;
    r.req.write  = write;
    r.req.mem_op = op;
    r.req.addr   = addr;
    r.req.wdata  = wdata;
    r.exp_err    = exp_err;
    r.ignore     = ignore;
    rows.push_back(r);
  endtask

  `include "lsu_vectors.svh"

  // little endian store of 1, 2, 4 or 8 bytes that wraps at the ram size.
  task automatic model_store(input lsu_req_t q);
    int unsigned base;
    int          n;
    base = q.addr;
    n    = 1 << q.mem_op[1:0];
    for (int i = 0; i < n; i++) begin
      ref_mem[(base + i) % RAM_BYTES] = q.wdata[8*i +: 8];
    end
  endtask

  function automatic dword_t model_load(input lsu_req_t q);
    int unsigned base;
    int          n;
    dword_t      val;
    base = q.addr;
    n    = 1 << q.mem_op[1:0];
    val  = '0;
    for (int i = 0; i < n; i++) begin
      val[8*i +: 8] = ref_mem[(base + i) % RAM_BYTES];
    end
    if (!q.mem_op[2] && n < 8 && val[8*n-1]) val = val | (~64'd0 << (8 * n)); // sign fill.
    return val;
  endfunction

  // one request plus an optional second req pulsed while the first is busy.
  task automatic run_access(input row_t r, input bit pulse_again, input row_t extra);
    int cycles;
    @(negedge clk);
    req      = 1'b1;
    req_data = r.req;
    @(negedge clk);
    req    = 1'b0;
    cycles = 0; // clock edges after the accepting one.
    if (pulse_again) begin
      req      = 1'b1;
      req_data = extra.req;
    end
    while (!done && !error) begin
      check_value("busy", 64'(busy), 64'd1);
      if (cycles > WAIT_CYCLES + 8) begin
        abort_run($sformatf("no done or error %0d cycles after request to %h",
                            cycles, r.req.addr));
      end
      @(negedge clk);
      req = 1'b0;
      cycles++;
    end
    check_value("busy", 64'(busy), 64'd1); // still high in the closing cycle.
    check_value("error", 64'(error), 64'(r.exp_err));
    check_value("done", 64'(done), 64'(!r.exp_err));
    if (r.exp_err) check_value("error latency", 64'(cycles), 64'd0); // up right after accept.
    else check_value("done latency", 64'(cycles), 64'(WAIT_CYCLES + 1));
    if (!r.exp_err && r.req.write) model_store(r.req);
    else if (!r.exp_err) expect_rdata = model_load(r.req);
    check_value("rdata", rdata, expect_rdata); // stores and errors keep the old value.
    @(negedge clk);
    req = 1'b0;
    check_idle();
    if (pulse_again) begin
      repeat (WAIT_CYCLES + 2) begin // no second completion.
        @(negedge clk);
        check_idle();
      end
    end
  endtask

  initial begin : watchdog
    wait (table_ready);
    repeat (rows.size() * (WAIT_CYCLES + 4) + 40) @(posedge clk);
    abort_run("timeout: the vector table did not finish in time");
  end

  initial begin
    int i;
    bit pair;
    seed     = 20016;
    rst      = 1'b1;
    req      = 1'b0;
    req_data = '0;
    fill_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_idle();
    check_value("rdata", rdata, 64'd0);
    i = 0;
    while (i < rows.size()) begin
      pair = (i + 1 < rows.size()) && rows[i + 1].ignore;
      run_access(rows[i], pair, pair ? rows[i + 1] : rows[i]);
      i += pair ? 2 : 1; // the ignored row rides along.
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
